// File: hw/traffic_pkg.sv
/*
 * shared widths, bus and stream structs, register map and region codes
 * NUM_CHANNELS is fixed at 2, and the decoder maps exactly two regions
 * pattern beat k of packet p: data[63:32] = p, data[31:0] = k
 */
package traffic_pkg;

	localparam int NUM_CHANNELS = 2;

	typedef logic [13:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [1:0]  region_t;
	typedef logic [11:0] reg_off_t;
	typedef logic [63:0] beat_t;
	typedef logic [2:0]  empty_t;
	typedef logic [15:0] pkt_count_t;
	typedef logic [7:0]  pkt_len_t;

	// register bus request and response
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t addr;
		data_t wdata;
	} csr_req_t;

	typedef struct packed {
		data_t rdata;
		logic  waitrequest;
	} csr_rsp_t;

	// one stream beat, valid and ready travel beside it
	typedef struct packed {
		beat_t  data;
		empty_t empty;
		logic   sop;
		logic   eop;
		logic   error;
	} st_beat_t;

	// address bits 13:12
	localparam region_t REGION_1588 = 2'd0;
	localparam region_t REGION_SEL  = 2'd1;
	localparam region_t REGION_CH0  = 2'd2;
	localparam region_t REGION_CH1  = 2'd3;

	// word offsets inside a channel region
	localparam reg_off_t REG_NUM_PKTS = 12'd0;
	localparam reg_off_t REG_PKT_LEN  = 12'd1;
	localparam reg_off_t REG_CTRL     = 12'd2;
	localparam reg_off_t REG_TX_COUNT = 12'd3;
	localparam reg_off_t REG_RX_GOOD  = 12'd4;
	localparam reg_off_t REG_RX_BAD   = 12'd5;

	typedef enum logic [1:0] {GEN_IDLE, GEN_SEND, GEN_FINISH} gen_state_t;

endpackage

// File: hw/csr_decoder.sv
/*
 * splits the register bus over two channel regions
 * regions 0 and 1 are reserved: zero read data, writes dropped, no wait
 * the master must hold its request until waitrequest is low
 */
`timescale 1ns/1ps

module csr_decoder (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  traffic_pkg::csr_req_t                               bus_req,
	input  traffic_pkg::csr_rsp_t [traffic_pkg::NUM_CHANNELS-1:0] ch_rsp,
	output traffic_pkg::csr_rsp_t                               bus_rsp,
	output traffic_pkg::csr_req_t [traffic_pkg::NUM_CHANNELS-1:0] ch_req
);

	traffic_pkg::region_t                  req_region;
	traffic_pkg::region_t                  sel_region;
	traffic_pkg::region_t                  held_region;
	logic                                  busy;
	logic [traffic_pkg::NUM_CHANNELS-1:0]  ch_sel;

	assign req_region = traffic_pkg::region_t'(bus_req.addr[13:12]);

	// target stays latched while a channel access waits
	assign sel_region = busy ? held_region : req_region;

	assign ch_sel[0] = (sel_region == traffic_pkg::REGION_CH0);
	assign ch_sel[1] = (sel_region == traffic_pkg::REGION_CH1);

	always_comb
	begin
		for (int i = 0; i < traffic_pkg::NUM_CHANNELS; i++)
		begin
			ch_req[i]       = bus_req;
			ch_req[i].read  = bus_req.read & ch_sel[i];
			ch_req[i].write = bus_req.write & ch_sel[i];
		end
	end

	// response mux, reserved regions answer at once
	always_comb
	begin
		case (sel_region)
			traffic_pkg::REGION_CH0:  bus_rsp = ch_rsp[0];
			traffic_pkg::REGION_CH1:  bus_rsp = ch_rsp[1];
			traffic_pkg::REGION_1588: bus_rsp = '0;
			traffic_pkg::REGION_SEL:  bus_rsp = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else
			busy <= (bus_req.read | bus_req.write) & bus_rsp.waitrequest;
	end

	always_ff @(posedge clk)
	begin
		held_region <= sel_region;
	end

endmodule

// File: hw/channel_regs.sv
/*
 * per-channel registers, every access takes one wait cycle
 * a PKT_LEN write of 0 is stored as 1
 * a start write while the generator is sending is dropped
 */
`timescale 1ns/1ps

module channel_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  traffic_pkg::csr_req_t   req,
	input  logic                    gen_active,
	input  logic                    gen_finished,
	input  traffic_pkg::pkt_count_t tx_count,
	input  traffic_pkg::pkt_count_t rx_good,
	input  traffic_pkg::pkt_count_t rx_bad,
	output traffic_pkg::csr_rsp_t   rsp,
	output traffic_pkg::pkt_count_t num_pkts,
	output traffic_pkg::pkt_len_t   pkt_len,
	output logic                    start,
	output logic                    mon_done,
	output logic                    mon_error
);

	logic                    ack;
	logic                    access;
	traffic_pkg::reg_off_t   off;
	traffic_pkg::data_t      rd_next;
	traffic_pkg::data_t      rdata_q;

	// first cycle of an access, completes when ack is high
	assign access = (req.read | req.write) & ~ack;
	assign off    = req.addr[11:0];

	assign rsp.waitrequest = access;
	assign rsp.rdata       = rdata_q;

	always_comb
	begin
		case (off)
			traffic_pkg::REG_NUM_PKTS: rd_next = {16'd0, num_pkts};
			traffic_pkg::REG_PKT_LEN:  rd_next = {24'd0, pkt_len};
			traffic_pkg::REG_CTRL:     rd_next = {29'd0, mon_error, mon_done, gen_active};
			traffic_pkg::REG_TX_COUNT: rd_next = {16'd0, tx_count};
			traffic_pkg::REG_RX_GOOD:  rd_next = {16'd0, rx_good};
			traffic_pkg::REG_RX_BAD:   rd_next = {16'd0, rx_bad};
			default:                   rd_next = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack      <= 1'b0;
			num_pkts <= '0;
			pkt_len  <= 8'd1;
			start    <= 1'b0;
		end
		else
		begin
			ack   <= access;
			start <= 1'b0;
			if (access & req.write)
			begin
				case (off)
					traffic_pkg::REG_NUM_PKTS: num_pkts <= req.wdata[15:0];
					traffic_pkg::REG_PKT_LEN:
						pkt_len <= (req.wdata[7:0] == 8'd0) ? 8'd1 : req.wdata[7:0];
					traffic_pkg::REG_CTRL:     start <= req.wdata[0] & ~gen_active;
					default:                   ;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (access & req.read)
			rdata_q <= rd_next;
	end

	//////////////////////////////////////////////////////////////////////
	// status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mon_done  <= 1'b0;
			mon_error <= 1'b0;
		end
		else
		begin
			// done once every sent packet has come back
			mon_done  <= ~start & gen_finished &
				(traffic_pkg::pkt_count_t'(rx_good + rx_bad) == tx_count);
			mon_error <= (rx_bad != '0);
		end
	end

endmodule

// File: hw/packet_generator.sv
/*
 * sends NUM_PKTS pattern packets of PKT_LEN beats each
 * settings are taken at start, later register writes wait for the next run
 * stop_mon ends the run at the next eop, so packets are always whole
 */
`timescale 1ns/1ps

module packet_generator (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    stop_mon,
	input  traffic_pkg::pkt_count_t num_pkts,
	input  traffic_pkg::pkt_len_t   pkt_len,
	input  logic                    tx_ready,
	output traffic_pkg::st_beat_t   tx_beat,
	output logic                    tx_valid,
	output logic                    active,
	output logic                    finished,
	output traffic_pkg::pkt_count_t tx_count
);

	traffic_pkg::gen_state_t state;
	traffic_pkg::pkt_count_t num_q;
	traffic_pkg::pkt_len_t   len_q;
	traffic_pkg::pkt_len_t   beat_idx;
	logic                    stop_q;
	logic                    xfer;
	logic                    last_beat;
	logic                    last_pkt;

	assign active   = (state == traffic_pkg::GEN_SEND);
	assign finished = (state == traffic_pkg::GEN_FINISH);
	assign tx_valid = active;
	assign xfer     = active & tx_ready;

	assign last_beat = (beat_idx == traffic_pkg::pkt_len_t'(len_q - 8'd1));
	// tx_count doubles as the number of the packet on the wire
	assign last_pkt  = (traffic_pkg::pkt_count_t'(tx_count + 16'd1) == num_q);

	// beat follows the counters, so it holds while ready is low
	always_comb
	begin
		tx_beat      = '0;
		tx_beat.data = {16'd0, tx_count, 24'd0, beat_idx};
		tx_beat.sop  = active & (beat_idx == '0);
		tx_beat.eop  = active & last_beat;
	end

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= traffic_pkg::GEN_IDLE;
			num_q    <= '0;
			len_q    <= 8'd1;
			beat_idx <= '0;
			stop_q   <= 1'b0;
			tx_count <= '0;
		end
		else
		begin
			case (state)
				traffic_pkg::GEN_IDLE, traffic_pkg::GEN_FINISH:
				begin
					if (start)
					begin
						num_q    <= num_pkts;
						len_q    <= pkt_len;
						beat_idx <= '0;
						stop_q   <= 1'b0;
						tx_count <= '0;
						// zero packets finishes straight away
						state    <= (num_pkts == '0) ? traffic_pkg::GEN_FINISH
							: traffic_pkg::GEN_SEND;
					end
				end
				traffic_pkg::GEN_SEND:
				begin
					stop_q <= stop_q | stop_mon;
					if (xfer)
					begin
						if (last_beat)
						begin
							beat_idx <= '0;
							tx_count <= tx_count + 16'd1;
							if (last_pkt | stop_q | stop_mon)
								state <= traffic_pkg::GEN_FINISH;
						end
						else
						begin
							beat_idx <= beat_idx + 8'd1;
						end
					end
				end
				default:
				begin
					state <= traffic_pkg::GEN_IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/packet_checker.sv
/*
 * checks received beats against the pattern rule and counts packets at eop
 * a packet is bad if any beat differs or sop/eop sit in the wrong place
 * expected numbering restarts at start, PKT_LEN is sampled there too
 */
`timescale 1ns/1ps

module packet_checker (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  traffic_pkg::pkt_len_t   pkt_len,
	input  traffic_pkg::st_beat_t   rx_beat,
	input  logic                    rx_valid,
	output logic                    rx_ready,
	output traffic_pkg::pkt_count_t rx_good,
	output traffic_pkg::pkt_count_t rx_bad
);

	logic                    ready_q;
	traffic_pkg::pkt_count_t exp_pkt;
	traffic_pkg::pkt_len_t   exp_beat;
	traffic_pkg::pkt_len_t   len_q;
	logic                    bad_q;
	logic                    accept;
	logic                    exp_sop;
	logic                    exp_eop;
	logic                    beat_ok;

	// ready rises on the first clock out of reset
	assign rx_ready = ready_q;
	assign accept   = rx_valid & ready_q;

	assign exp_sop = (exp_beat == '0);
	assign exp_eop = (exp_beat == traffic_pkg::pkt_len_t'(len_q - 8'd1));

	assign beat_ok = (rx_beat.data == {16'd0, exp_pkt, 24'd0, exp_beat}) &&
		(rx_beat.empty == '0) && !rx_beat.error &&
		(rx_beat.sop == exp_sop) && (rx_beat.eop == exp_eop);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ready_q  <= 1'b0;
			exp_pkt  <= '0;
			exp_beat <= '0;
			len_q    <= 8'd1;
			bad_q    <= 1'b0;
			rx_good  <= '0;
			rx_bad   <= '0;
		end
		else
		begin
			ready_q <= 1'b1;
			if (start)
			begin
				exp_pkt  <= '0;
				exp_beat <= '0;
				len_q    <= pkt_len;
				bad_q    <= 1'b0;
				rx_good  <= '0;
				rx_bad   <= '0;
			end
			else if (accept)
			begin
				if (rx_beat.eop)
				begin
					// verdict for the whole packet
					if (bad_q | ~beat_ok)
						rx_bad <= rx_bad + 16'd1;
					else
						rx_good <= rx_good + 16'd1;
					exp_pkt  <= exp_pkt + 16'd1;
					exp_beat <= '0;
					bad_q    <= 1'b0;
				end
				else
				begin
					exp_beat <= exp_beat + 8'd1;
					bad_q    <= bad_q | ~beat_ok;
				end
			end
		end
	end

endmodule

// File: hw/eth_traffic_controller_top.sv
/*
 * two traffic channels behind one register bus
 * region 2 reaches channel 0, region 3 channel 1, regions 0 and 1 read zero
 * each channel generates on tx and checks on rx, loopback is external
 */
`timescale 1ns/1ps

module eth_traffic_controller_top (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic                                                 avl_mm_read,
	input  logic                                                 avl_mm_write,
	input  traffic_pkg::addr_t                                   avl_mm_address,
	input  traffic_pkg::data_t                                   avl_mm_writedata,
	output traffic_pkg::data_t                                   avl_mm_readdata,
	output logic                                                 avl_mm_waitrequest,
	input  logic [traffic_pkg::NUM_CHANNELS-1:0]                 stop_mon,
	input  logic [traffic_pkg::NUM_CHANNELS-1:0]                 tx_ready,
	output traffic_pkg::st_beat_t [traffic_pkg::NUM_CHANNELS-1:0] tx_beat,
	output logic [traffic_pkg::NUM_CHANNELS-1:0]                 tx_valid,
	input  traffic_pkg::st_beat_t [traffic_pkg::NUM_CHANNELS-1:0] rx_beat,
	input  logic [traffic_pkg::NUM_CHANNELS-1:0]                 rx_valid,
	output logic [traffic_pkg::NUM_CHANNELS-1:0]                 rx_ready,
	output logic [traffic_pkg::NUM_CHANNELS-1:0]                 mon_active,
	output logic [traffic_pkg::NUM_CHANNELS-1:0]                 mon_done,
	output logic [traffic_pkg::NUM_CHANNELS-1:0]                 mon_error
);

	traffic_pkg::csr_req_t                                bus_req;
	traffic_pkg::csr_rsp_t                                bus_rsp;
	traffic_pkg::csr_req_t [traffic_pkg::NUM_CHANNELS-1:0] ch_req;
	traffic_pkg::csr_rsp_t [traffic_pkg::NUM_CHANNELS-1:0] ch_rsp;

	assign bus_req.read       = avl_mm_read;
	assign bus_req.write      = avl_mm_write;
	assign bus_req.addr       = avl_mm_address;
	assign bus_req.wdata      = avl_mm_writedata;
	assign avl_mm_readdata    = bus_rsp.rdata;
	assign avl_mm_waitrequest = bus_rsp.waitrequest;

	csr_decoder csr_decoder_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.bus_req (bus_req),
		.ch_rsp  (ch_rsp),
		.bus_rsp (bus_rsp),
		.ch_req  (ch_req)
	);

	//////////////////////////////////////////////////////////////////////
	// channels
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < traffic_pkg::NUM_CHANNELS; i++)
	begin : g_channel
		traffic_pkg::pkt_count_t num_pkts;
		traffic_pkg::pkt_len_t   pkt_len;
		traffic_pkg::pkt_count_t tx_count;
		traffic_pkg::pkt_count_t rx_good;
		traffic_pkg::pkt_count_t rx_bad;
		logic                    start;
		logic                    gen_finished;

		channel_regs channel_regs_inst (
			.clk          (clk),
			.rst_n        (rst_n),
			.req          (ch_req[i]),
			.gen_active   (mon_active[i]),
			.gen_finished (gen_finished),
			.tx_count     (tx_count),
			.rx_good      (rx_good),
			.rx_bad       (rx_bad),
			.rsp          (ch_rsp[i]),
			.num_pkts     (num_pkts),
			.pkt_len      (pkt_len),
			.start        (start),
			.mon_done     (mon_done[i]),
			.mon_error    (mon_error[i])
		);

		packet_generator packet_generator_inst (
			.clk      (clk),
			.rst_n    (rst_n),
			.start    (start),
			.stop_mon (stop_mon[i]),
			.num_pkts (num_pkts),
			.pkt_len  (pkt_len),
			.tx_ready (tx_ready[i]),
			.tx_beat  (tx_beat[i]),
			.tx_valid (tx_valid[i]),
			.active   (mon_active[i]),
			.finished (gen_finished),
			.tx_count (tx_count)
		);

		packet_checker packet_checker_inst (
			.clk      (clk),
			.rst_n    (rst_n),
			.start    (start),
			.pkt_len  (pkt_len),
			.rx_beat  (rx_beat[i]),
			.rx_valid (rx_valid[i]),
			.rx_ready (rx_ready[i]),
			.rx_good  (rx_good),
			.rx_bad   (rx_bad)
		);
	end

endmodule

// File: testbench/packet_generator_chk.sv
/*
 * stream protocol checks on the generator's tx side
 * bound to every packet_generator instance
 */
`timescale 1ns/1ps

module packet_generator_chk (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  tx_valid,
	input logic                  tx_ready,
	input traffic_pkg::st_beat_t tx_beat
);

	// a stalled beat stays on the bus unchanged
	hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
		else $error("tx beat or valid changed while ready was low");

	// the beat after an accepted eop opens the next packet
	sop_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
		tx_valid && tx_ready && tx_beat.eop |=> !tx_valid || tx_beat.sop)
		else $error("beat after eop did not carry sop");

	valid_low_in_reset: assert property (@(posedge clk)
		!rst_n |=> !tx_valid)
		else $error("tx valid high during reset");

endmodule

bind packet_generator packet_generator_chk packet_generator_chk_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.tx_valid (tx_valid),
	.tx_ready (tx_ready),
	.tx_beat  (tx_beat)
);

// File: testbench/tb_eth_traffic_controller.sv
/*
 * tx is looped back to rx outside the DUT, tx_ready is random every cycle
 * a tx beat model checks every transferred beat against the pattern rule
 * stops at the first failed check, every wait has its own cycle limit
 */
`timescale 1ns/1ps

module tb_eth_traffic_controller;

	logic                                                 clk = 1'b0;
	logic                                                 rst_n;
	logic                                                 avl_mm_read;
	logic                                                 avl_mm_write;
	traffic_pkg::addr_t                                   avl_mm_address;
	traffic_pkg::data_t                                   avl_mm_writedata;
	traffic_pkg::data_t                                   avl_mm_readdata;
	logic                                                 avl_mm_waitrequest;
	logic [1:0]                                           stop_mon;
	logic [1:0]                                           tx_ready;
	traffic_pkg::st_beat_t [traffic_pkg::NUM_CHANNELS-1:0] tx_beat;
	traffic_pkg::st_beat_t [traffic_pkg::NUM_CHANNELS-1:0] rx_beat;
	logic [1:0]                                           tx_valid;
	logic [1:0]                                           rx_valid;
	logic [1:0]                                           rx_ready;
	logic [1:0]                                           mon_active;
	logic [1:0]                                           mon_done;
	logic [1:0]                                           mon_error;

	integer             seed;
	string              test_name;
	logic [1:0]         corrupt_en;
	traffic_pkg::beat_t corrupt_word [2];
	int                 run_id [2];
	int                 run_len [2];
	int                 seen_id [2];
	int                 m_pkt [2];
	int                 m_beat [2];
	int                 m_sent [2];
	traffic_pkg::data_t v;
	traffic_pkg::data_t saved [2];
	int                 n0;
	int                 len0;
	int                 stop_count;

	always #50 clk = ~clk;

	eth_traffic_controller_top eth_traffic_controller_top_inst (.*);

	// loopback, one data bit flipped on the chosen beat
	assign rx_valid = tx_valid & tx_ready;
	always_comb
	begin
		for (int i = 0; i < traffic_pkg::NUM_CHANNELS; i++)
		begin
			rx_beat[i] = tx_beat[i];
			if (corrupt_en[i] && tx_beat[i].data == corrupt_word[i])
				rx_beat[i].data[40] = ~tx_beat[i].data[40];
		end
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [71:0] exp, input logic [71:0] act);
		assert (exp === act)
		else
			abort_run($sformatf("Mismatch %s %s: expected %0h, actual %0h",
				test_name, what, exp, act));
	endtask

	function automatic traffic_pkg::st_beat_t expected_beat(input int p, input int k,
		input int len);
		traffic_pkg::st_beat_t b;
		b      = '0;
		b.data = {p, k};
		b.sop  = (k == 0);
		b.eop  = (k == len - 1);
		return b;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// tx model, sampled mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		for (int i = 0; i < traffic_pkg::NUM_CHANNELS; i++)
		begin
			if (run_id[i] != seen_id[i])
			begin
				seen_id[i] = run_id[i];
				m_pkt[i]   = 0;
				m_beat[i]  = 0;
				m_sent[i]  = 0;
			end
			else if (rst_n && tx_valid[i] && tx_ready[i])
			begin
				check_value($sformatf("tx beat ch%0d", i),
					72'(expected_beat(m_pkt[i], m_beat[i], run_len[i])), 72'(tx_beat[i]));
				m_beat[i] = m_beat[i] + 1;
				if (m_beat[i] == run_len[i])
				begin
					m_beat[i] = 0;
					m_pkt[i]  = m_pkt[i] + 1;
					m_sent[i] = m_sent[i] + 1;
				end
			end
		end
	end

	task automatic drive_ready();
		logic [31:0] r;
		forever
		begin
			@(posedge clk);
			#1;
			r        = $random(seed);
			tx_ready = {r[3:2] != 2'd0, r[1:0] != 2'd0};
		end
	endtask

	task automatic bus_access(input logic wr, input traffic_pkg::addr_t addr,
		input traffic_pkg::data_t wdata, output traffic_pkg::data_t rdata);
		int   n;
		logic done;
		@(posedge clk);
		#1;
		avl_mm_read      = ~wr;
		avl_mm_write     = wr;
		avl_mm_address   = addr;
		avl_mm_writedata = wdata;
		done = 1'b0;
		for (n = 0; n < 50 && !done; n++)
		begin
			@(negedge clk);
			done = !avl_mm_waitrequest;
		end
		assert (done) else abort_run("bus access never completed, waitrequest stuck high");
		rdata = avl_mm_readdata;
		@(posedge clk);
		#1;
		avl_mm_read  = 1'b0;
		avl_mm_write = 1'b0;
	endtask

	function automatic traffic_pkg::region_t ch_region(input int ch);
		return (ch == 0) ? traffic_pkg::REGION_CH0 : traffic_pkg::REGION_CH1;
	endfunction

	task automatic reg_write(input traffic_pkg::region_t r, input traffic_pkg::reg_off_t off,
		input traffic_pkg::data_t data);
		traffic_pkg::data_t unused;
		bus_access(1'b1, {r, off}, data, unused);
	endtask

	task automatic reg_check(input traffic_pkg::region_t r, input traffic_pkg::reg_off_t off,
		input traffic_pkg::data_t exp, input string what);
		traffic_pkg::data_t rd;
		bus_access(1'b0, {r, off}, '0, rd);
		check_value(what, 72'(exp), 72'(rd));
	endtask

	task automatic start_run(input int ch, input int n, input int len);
		reg_write(ch_region(ch), traffic_pkg::REG_NUM_PKTS, traffic_pkg::data_t'(n));
		reg_write(ch_region(ch), traffic_pkg::REG_PKT_LEN, traffic_pkg::data_t'(len));
		run_len[ch] = len;
		run_id[ch]  = run_id[ch] + 1;
		reg_write(ch_region(ch), traffic_pkg::REG_CTRL, 32'd1);
	endtask

	task automatic wait_done(input int ch);
		int   n;
		logic done;
		done = 1'b0;
		// long runs with a slow ready need many cycles
		for (n = 0; n < 20000 && !done; n++)
		begin
			@(negedge clk);
			done = mon_done[ch];
		end
		assert (done) else abort_run($sformatf("channel %0d never raised mon_done", ch));
	endtask

	// the model counts at negedge, so look at it on the rising edge
	task automatic wait_sent(input int ch, input int count);
		int   n;
		logic done;
		done = 1'b0;
		for (n = 0; n < 5000 && !done; n++)
		begin
			@(posedge clk);
			done = (m_sent[ch] >= count);
		end
		assert (done) else abort_run($sformatf("channel %0d sent too few packets", ch));
	endtask

	task automatic check_counts(input int ch, input int tx, input int good, input int bad);
		reg_check(ch_region(ch), traffic_pkg::REG_TX_COUNT, traffic_pkg::data_t'(tx), "TX_COUNT");
		reg_check(ch_region(ch), traffic_pkg::REG_RX_GOOD, traffic_pkg::data_t'(good), "RX_GOOD");
		reg_check(ch_region(ch), traffic_pkg::REG_RX_BAD, traffic_pkg::data_t'(bad), "RX_BAD");
		check_value("model packet count", 72'(tx), 72'(m_sent[ch]));
	endtask

	task automatic check_status(input int ch, input logic act, input logic done, input logic err);
		check_value("mon_active", 72'(act), 72'(mon_active[ch]));
		check_value("mon_done", 72'(done), 72'(mon_done[ch]));
		check_value("mon_error", 72'(err), 72'(mon_error[ch]));
		reg_check(ch_region(ch), traffic_pkg::REG_CTRL, {29'd0, err, done, act}, "CTRL status");
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed             = 32'h35d2;
		test_name        = "reset";
		rst_n            = 1'b0;
		avl_mm_read      = 1'b0;
		avl_mm_write     = 1'b0;
		avl_mm_address   = '0;
		avl_mm_writedata = '0;
		stop_mon         = '0;
		tx_ready         = '0;
		corrupt_en       = '0;
		corrupt_word     = '{64'd0, 64'd0};
		run_id           = '{0, 0};
		run_len          = '{1, 1};
		fork
			drive_ready();
		join_none
		repeat (16) @(posedge clk);
		#1;
		// still in reset here
		check_value("rx_ready in reset", 72'(2'b00), 72'(rx_ready));
		check_value("status in reset", 72'(6'd0), 72'({mon_active, mon_done, mon_error}));
		rst_n = 1'b1;

		test_name = "register readback";
		reg_write(traffic_pkg::REGION_CH0, traffic_pkg::REG_PKT_LEN, 32'd0);
		reg_check(traffic_pkg::REGION_CH0, traffic_pkg::REG_PKT_LEN, 32'd1, "PKT_LEN of 0");
		for (int ch = 0; ch < 2; ch++)
		begin
			v = $random(seed);
			saved[ch] = v;
			reg_write(ch_region(ch), traffic_pkg::REG_NUM_PKTS, {16'd0, v[15:0]});
			reg_write(ch_region(ch), traffic_pkg::REG_PKT_LEN, {24'd0, v[23:16]});
		end
		// regions 0 and 1, offsets up to CTRL
		for (int r = 0; r < 2; r++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				reg_write(traffic_pkg::region_t'(r), traffic_pkg::reg_off_t'(k), $random(seed));
				reg_check(traffic_pkg::region_t'(r), traffic_pkg::reg_off_t'(k), '0, "reserved");
			end
		end
		for (int ch = 0; ch < 2; ch++)
		begin
			reg_check(ch_region(ch), traffic_pkg::REG_NUM_PKTS, {16'd0, saved[ch][15:0]}, "NUM_PKTS");
			reg_check(ch_region(ch), traffic_pkg::REG_PKT_LEN,
				(saved[ch][23:16] == 8'd0) ? 32'd1 : {24'd0, saved[ch][23:16]}, "PKT_LEN");
		end
		check_value("rx_ready", 72'(2'b11), 72'(rx_ready));

		test_name = "two channel run";
		v    = $random(seed);
		n0   = 4 + int'(v[1:0]);
		len0 = 1 + int'(v[4:2]);
		start_run(0, n0, len0);
		start_run(1, n0 + 3, len0 + 2);
		wait_done(0);
		wait_done(1);
		check_counts(0, n0, n0, 0);
		check_counts(1, n0 + 3, n0 + 3, 0);
		check_status(0, 1'b0, 1'b1, 1'b0);
		check_status(1, 1'b0, 1'b1, 1'b0);

		test_name       = "corrupted beat";
		corrupt_word[0] = {32'd2, 32'd1};
		corrupt_en[0]   = 1'b1;
		start_run(0, 4, 3);
		wait_done(0);
		corrupt_en[0] = 1'b0;
		check_counts(0, 4, 3, 1);
		check_status(0, 1'b0, 1'b1, 1'b1);

		test_name = "stop mid run";
		start_run(1, 40, 4);
		wait_sent(1, 3);
		@(posedge clk);
		#1;
		stop_mon[1] = 1'b1;
		// the packet in progress is the last one sent
		stop_count  = m_sent[1] + 1;
		wait_done(1);
		@(posedge clk);
		#1;
		stop_mon[1] = 1'b0;
		check_counts(1, stop_count, stop_count, 0);
		check_status(1, 1'b0, 1'b1, 1'b0);

		$display("TEST OK");
		$finish;
	end

endmodule

// File: src.f
hw/traffic_pkg.sv
hw/csr_decoder.sv
hw/channel_regs.sv
hw/packet_generator.sv
hw/packet_checker.sv
hw/eth_traffic_controller_top.sv
testbench/packet_generator_chk.sv
testbench/tb_eth_traffic_controller.sv

// File: Makefile
# Verilator build and run of the traffic controller testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line in sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f \
		--top-module tb_eth_traffic_controller -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	@grep -q "^TEST OK$$" sim.log && echo "simulation passed" || \
		(echo "simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
